// File: Makefile
TOP = execLaneTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f execLane.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f execLane.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// File: execLane.f
src/execPkg.sv
src/isaPkg.sv
src/laneDispatch.sv
src/multiplyAddUnit.sv
src/loadStoreUnit.sv
src/resultQueue.sv
src/writeBackSelect.sv
src/execLane.sv
verif/execLane_properties.sv
verif/execLaneTb.sv

// File: src/execLane.sv
`timescale 1ns/10ps
`default_nettype none

module execLane
	import execPkg::*, isaPkg::*;
#(
	parameter int MUL_DEPTH   = 3,
	parameter int QUEUE_DEPTH = 4
)(
	input  wire              clock,
	input  wire              reset,
	input  wire              cmdValid,
	input  wire command_t    cmd,
	output logic             busy,
	input  wire              stall,
	output logic [1:0]       ldSt,
	output logic [1:0]       isStore,
	output data_t [1:0]      memAddr,
	output data_t [1:0]      stData,
	input  wire  [1:0]       grant,
	input  wire  [1:0]       endAccess,
	input  wire data_t [1:0] ldData,
	output logic [1:0]       done,
	output logic             wbValid,
	output wbEntry_t         wb
);

	logic           mathReq;
	logic [1:0]     memReq;
	wbEntry_t       token;
	issueNo_t       curIssueNo;
	logic           mathFull;
	logic           mathInFlight;
	logic           mathValid;
	wbEntry_t       mathResult;
	logic [1:0]     memBusy;
	logic [2:0]     queueNotEmpty;
	logic [2:0]     queueAlmostFull;
	wbEntry_t [2:0] queueHead;	// 0 math, 1 even, 2 odd
	logic [2:0]     pop;

	// Math waits for an empty pipe so the spare queue slot covers it
	assign mathFull = queueAlmostFull[0] | mathInFlight;

	//////////////////////////////////////////////////////////////////////
	// Producer
	//////////////////////////////////////////////////////////////////////

	laneDispatch i_dispatch (
		.clock,
		.reset,
		.cmdValid,
		.cmd,
		.mathFull,
		.memBusy,
		.memFull    (queueAlmostFull[2:1]),
		.busy,
		.mathReq,
		.memReq,
		.token,
		.curIssueNo
	);

	multiplyAddUnit #(.MUL_DEPTH(MUL_DEPTH)) i_mulAdd (
		.clock,
		.reset,
		.req        (mathReq),
		.src1       (cmd.src1),
		.src2       (cmd.src2),
		.src3       (cmd.src3),
		.tokenIn    (token),
		.valid      (mathValid),
		.result     (mathResult),
		.inFlight   (mathInFlight)
	);

	resultQueue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_mathQueue (
		.clock,
		.reset,
		.push       (mathValid),
		.pushData   (mathResult),
		.pop        (pop[0]),
		.notEmpty   (queueNotEmpty[0]),
		.head       (queueHead[0]),
		.almostFull (queueAlmostFull[0])
	);

	// Even port at index 0, odd port at index 1
	for (genvar p = 0; p < 2; p++) begin : g_port
		logic     ldValid;
		wbEntry_t ldResult;

		loadStoreUnit i_ldSt (
			.clock,
			.reset,
			.req        (memReq[p]),
			.cmd,
			.tokenIn    (token),
			.ldSt       (ldSt[p]),
			.isStore    (isStore[p]),
			.memAddr    (memAddr[p]),
			.stData     (stData[p]),
			.grant      (grant[p]),
			.endAccess  (endAccess[p]),
			.ldData     (ldData[p]),
			.busy       (memBusy[p]),
			.done       (done[p]),
			.valid      (ldValid),
			.result     (ldResult)
		);

		resultQueue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_memQueue (
			.clock,
			.reset,
			.push       (ldValid),
			.pushData   (ldResult),
			.pop        (pop[p+1]),
			.notEmpty   (queueNotEmpty[p+1]),
			.head       (queueHead[p+1]),
			.almostFull (queueAlmostFull[p+1])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Consumer
	//////////////////////////////////////////////////////////////////////

	writeBackSelect i_wbSelect (
		.curIssueNo,
		.stall,
		.notEmpty   (queueNotEmpty),
		.head0      (queueHead[0]),
		.head1      (queueHead[1]),
		.head2      (queueHead[2]),
		.pop,
		.wbValid,
		.wb
	);

endmodule

`default_nettype wire

// File: src/execPkg.sv
`default_nettype none

package execPkg;

	//////////////////////////////////////////////////////////////////////
	// Data path widths
	//////////////////////////////////////////////////////////////////////

	localparam int DATA_WIDTH  = 32;	// Operand width
	localparam int ISSUE_WIDTH = 6;		// Issue number bits
	localparam int INDEX_WIDTH = 5;		// Register index bits

	typedef logic [DATA_WIDTH-1:0]  data_t;
	typedef logic [ISSUE_WIDTH-1:0] issueNo_t;	// Wraps at 64
	typedef logic [INDEX_WIDTH-1:0] index_t;

	//////////////////////////////////////////////////////////////////////
	// Write-back token
	//////////////////////////////////////////////////////////////////////

	// Travels with an operation from dispatch to write-back
	typedef struct packed {
		index_t   dst;		// Destination register
		data_t    data;		// Math result or loaded word
		issueNo_t issueNo;	// Age stamp from dispatch
	} wbEntry_t;

endpackage

`default_nettype wire

// File: src/isaPkg.sv
`default_nettype none

package isaPkg;

	import execPkg::*;

	//////////////////////////////////////////////////////////////////////
	// Command word
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		MATH   = 2'b00,		// Multiply-add
		RSVD_A = 2'b01,
		RSVD_B = 2'b10,
		MEM    = 2'b11		// Load or store
	} opType_t;

	typedef struct packed {
		opType_t    opType;
		index_t     dst;
		logic [8:0] unused;
	} mathOp_t;

	typedef struct packed {
		opType_t    opType;
		index_t     dst;
		logic       port;		// 0 even, 1 odd
		logic       store;		// 0 load, 1 store
		logic [6:0] unused;
	} memOp_t;

	// opType and dst sit in the same bits in both views
	typedef union packed {
		mathOp_t math;
		memOp_t  mem;
	} instr_u;

	typedef struct packed {
		instr_u instr;
		data_t  src1;		// Multiplicand or store data
		data_t  src2;		// Multiplier or address
		data_t  src3;		// Addend
	} command_t;

endpackage

`default_nettype wire

// File: src/laneDispatch.sv
`timescale 1ns/10ps
`default_nettype none

module laneDispatch
	import execPkg::*, isaPkg::*;
(
	input  wire             clock,
	input  wire             reset,
	input  wire             cmdValid,
	input  wire command_t   cmd,
	input  wire             mathFull,
	input  wire  [1:0]      memBusy,
	input  wire  [1:0]      memFull,
	output logic            busy,
	output logic            mathReq,
	output logic [1:0]      memReq,
	output wbEntry_t        token,
	output issueNo_t        curIssueNo
);

	opType_t opType;
	logic    isMath;
	logic    isMem;
	logic    port;
	logic    accept;

	assign opType = cmd.instr.math.opType;	// Same field in the memory view
	assign isMath = (opType == MATH);
	assign isMem  = (opType == MEM);
	assign port   = cmd.instr.mem.port;

	// Status of the unit and queue this command would go to
	assign busy = isMath ? mathFull :
		isMem ? (memBusy[port] | memFull[port]) : 1'b0;

	assign accept = cmdValid & ~busy & (isMath | isMem);	// Reserved codes dropped

	assign mathReq   = accept & isMath;
	assign memReq[0] = accept & isMem & ~port;
	assign memReq[1] = accept & isMem & port;

	always_comb begin
		token         = '0;
		token.dst     = cmd.instr.math.dst;	// Same bits in the memory view
		token.issueNo = curIssueNo;
	end

	// Next issue number
	always_ff @(posedge clock) begin
		if (reset) begin
			curIssueNo <= '0;
		end else if (accept) begin
			curIssueNo <= curIssueNo + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: src/loadStoreUnit.sv
`timescale 1ns/10ps
`default_nettype none

module loadStoreUnit
	import execPkg::*, isaPkg::*;
(
	input  wire             clock,
	input  wire             reset,
	input  wire             req,
	input  wire command_t   cmd,
	input  wire wbEntry_t   tokenIn,
	output logic            ldSt,
	output logic            isStore,
	output data_t           memAddr,
	output data_t           stData,
	input  wire             grant,
	input  wire             endAccess,
	input  wire data_t      ldData,
	output logic            busy,
	output logic            done,
	output logic            valid,
	output wbEntry_t        result
);

	localparam logic [1:0] IDLE    = 2'd0;
	localparam logic [1:0] REQUEST = 2'd1;
	localparam logic [1:0] ACCESS  = 2'd2;

	logic [1:0] state;
	logic       storeReg;
	data_t      addrReg;
	data_t      dataReg;
	wbEntry_t   tokenReg;
	logic       doneReg;
	logic       validReg;

	//////////////////////////////////////////////////////////////////////
	// Port FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= IDLE;
			doneReg  <= 1'b0;
			validReg <= 1'b0;
		end else begin
			doneReg  <= 1'b0;
			validReg <= 1'b0;
			case (state)
				IDLE: begin
					if (req) begin
						state <= REQUEST;
					end
				end
				REQUEST: begin
					if (grant) begin
						state <= ACCESS;	// Drop request next cycle
					end
				end
				ACCESS: begin
					if (endAccess) begin
						state    <= IDLE;
						doneReg  <= 1'b1;
						validReg <= ~storeReg;	// Only loads write back
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Command and token captured at the request
	always_ff @(posedge clock) begin
		if (state == IDLE && req) begin
			storeReg <= cmd.instr.mem.store;
			addrReg  <= cmd.src2;
			dataReg  <= cmd.src1;
			tokenReg <= tokenIn;
		end
		if (state == ACCESS && endAccess) begin
			tokenReg.data <= ldData;	// Loaded word into the token
		end
	end

	assign ldSt    = (state == REQUEST);
	assign isStore = storeReg;
	assign memAddr = addrReg;
	assign stData  = dataReg;
	assign busy    = (state != IDLE);
	assign done    = doneReg;
	assign valid   = validReg;
	assign result  = tokenReg;

endmodule

`default_nettype wire

// File: src/multiplyAddUnit.sv
`timescale 1ns/10ps
`default_nettype none

module multiplyAddUnit
	import execPkg::*;
#(
	parameter int MUL_DEPTH = 3
)(
	input  wire             clock,
	input  wire             reset,
	input  wire             req,
	input  wire data_t      src1,
	input  wire data_t      src2,
	input  wire data_t      src3,
	input  wire wbEntry_t   tokenIn,
	output logic            valid,
	output wbEntry_t        result,
	output logic            inFlight
);

	wbEntry_t               stage [MUL_DEPTH];
	logic [MUL_DEPTH-1:0]   stageValid;
	data_t                  mulAdd;
	wbEntry_t               entry;

	assign mulAdd = src1 * src2 + src3;	// Truncated to 32 bits

	always_comb begin
		entry      = tokenIn;
		entry.data = mulAdd;
	end

	// Valid bits of the shift pipeline
	always_ff @(posedge clock) begin
		if (reset) begin
			stageValid <= '0;
		end else begin
			stageValid[0] <= req;
			for (int i = 1; i < MUL_DEPTH; i++) begin
				stageValid[i] <= stageValid[i-1];
			end
		end
	end

	// Tokens move along with their valid bit
	always_ff @(posedge clock) begin
		stage[0] <= entry;
		for (int i = 1; i < MUL_DEPTH; i++) begin
			stage[i] <= stage[i-1];
		end
	end

	assign valid    = stageValid[MUL_DEPTH-1];
	assign result   = stage[MUL_DEPTH-1];
	assign inFlight = |stageValid;	// Any stage occupied

endmodule

`default_nettype wire

// File: src/resultQueue.sv
`timescale 1ns/10ps
`default_nettype none

module resultQueue
	import execPkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)(
	input  wire             clock,
	input  wire             reset,
	input  wire             push,
	input  wire wbEntry_t   pushData,
	input  wire             pop,
	output logic            notEmpty,
	output wbEntry_t        head,
	output logic            almostFull
);

	localparam int PTR_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

	wbEntry_t             entries [QUEUE_DEPTH];
	logic [PTR_WIDTH-1:0] wrPtr;
	logic [PTR_WIDTH-1:0] rdPtr;
	logic [CNT_WIDTH-1:0] count;
	logic                 wrEn;
	logic                 rdEn;

	assign wrEn = push && (count != CNT_WIDTH'(QUEUE_DEPTH));
	assign rdEn = pop && notEmpty;

	always_ff @(posedge clock) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (wrEn) begin
				wrPtr <= (wrPtr == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (rdEn) begin
				rdPtr <= (rdPtr == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({wrEn, rdEn})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (wrEn) begin
			entries[wrPtr] <= pushData;
		end
	end

	assign notEmpty   = (count != '0);
	assign head       = entries[rdPtr];
	assign almostFull = (count >= CNT_WIDTH'(QUEUE_DEPTH - 1));	// One slot or less left

endmodule

`default_nettype wire

// File: src/writeBackSelect.sv
`timescale 1ns/10ps
`default_nettype none

module writeBackSelect
	import execPkg::*;
(
	input  wire issueNo_t   curIssueNo,
	input  wire             stall,
	input  wire  [2:0]      notEmpty,
	input  wire wbEntry_t   head0,
	input  wire wbEntry_t   head1,
	input  wire wbEntry_t   head2,
	output logic [2:0]      pop,
	output logic            wbValid,
	output wbEntry_t        wb
);

	issueNo_t   life0;
	issueNo_t   life1;
	issueNo_t   life2;
	logic [2:0] pick;

	// Age of each head modulo 64
	assign life0 = curIssueNo - head0.issueNo;
	assign life1 = curIssueNo - head1.issueNo;
	assign life2 = curIssueNo - head2.issueNo;

	// Oldest present head wins
	always_comb begin
		pick = '0;
		if (notEmpty[0] && (!notEmpty[1] || life0 > life1)
				&& (!notEmpty[2] || life0 > life2)) begin
			pick[0] = 1'b1;
		end else if (notEmpty[1] && (!notEmpty[2] || life1 > life2)) begin
			pick[1] = 1'b1;
		end else if (notEmpty[2]) begin
			pick[2] = 1'b1;
		end
	end

	assign wbValid = (|pick) & ~stall;
	assign pop     = stall ? 3'b000 : pick;
	assign wb      = pick[0] ? head0 :
		pick[1] ? head1 : head2;

endmodule

`default_nettype wire

// File: verif/execLaneTb.sv
`timescale 1ns/10ps
`default_nettype none

module execLaneTb
	import execPkg::*, isaPkg::*;
();

	logic        clock;
	logic        reset;
	logic        cmdValid;
	command_t    cmd;
	logic        busy;
	logic        stall;
	logic [1:0]  ldSt;
	logic [1:0]  isStore;
	data_t [1:0] memAddr;
	data_t [1:0] stData;
	logic [1:0]  grant;
	logic [1:0]  endAccess;
	data_t [1:0] ldData;
	logic [1:0]  done;
	logic        wbValid;
	wbEntry_t    wb;

	data_t       mem [256];		// Shared by both ports
	wbEntry_t    expQ [$];		// Write-backs still owed
	int          seed;
	int          stallOn;
	int          stallOff;
	int          phase;
	int          testNo;
	int          ordered;		// Nonzero when results must come in issue order
	int          testErrors;
	int          passCount;
	int          failCount;
	int          lineCount;
	int          memOps [2];
	int          doneCount [2];

	execLane #(.MUL_DEPTH(3), .QUEUE_DEPTH(4)) i_dut (
		.clock,
		.reset,
		.cmdValid,
		.cmd,
		.busy,
		.stall,
		.ldSt,
		.isStore,
		.memAddr,
		.stData,
		.grant,
		.endAccess,
		.ldData,
		.done,
		.wbValid,
		.wb
	);

	bind execLane execLaneProperties i_props (
		.clock    (clock),
		.reset    (reset),
		.cmdValid (cmdValid),
		.busy     (busy),
		.ldSt     (ldSt),
		.grant    (grant),
		.stall    (stall),
		.wbValid  (wbValid),
		.pop      (pop)
	);

	always #50 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Each step ends 1 ns after a rising edge
	task automatic nextCycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic logError(input string text);
		$display("%s", text);
		testErrors++;
	endtask

	function automatic int accessDelay();
		return 1 + int'($unsigned($random(seed)) % 4);	// 1 to 4 cycles
	endfunction

	task automatic servePort(input logic p);
		logic [7:0] addr;
		logic       store;
		forever begin
			nextCycles(1);
			if (ldSt[p]) begin
				nextCycles(accessDelay() - 1);
				grant[p] = 1'b1;
				addr     = memAddr[p][7:0];
				store    = isStore[p];
				nextCycles(1);
				grant[p] = 1'b0;
				nextCycles(accessDelay() - 1);
				endAccess[p] = 1'b1;
				ldData[p]    = mem[addr];
				if (store) begin
					mem[addr] = stData[p];
				end
				nextCycles(1);
				endAccess[p] = 1'b0;
			end
		end
	endtask

	task automatic issueCommand(input command_t c, output logic accepted);
		int waited;
		cmd = c;
		#1;	// Busy follows the command combinationally
		waited = 0;
		while (busy && waited < 100) begin
			nextCycles(1);
			waited++;
		end
		accepted = !busy;
		if (!accepted) begin
			logError($sformatf("Test %0d: command stayed blocked by busy", testNo));
		end else begin
			cmdValid = 1'b1;
			nextCycles(1);
			cmdValid = 1'b0;
		end
	endtask

	task automatic sendMath(input index_t dst, input data_t s1, input data_t s2,
			input data_t s3);
		command_t c;
		logic     accepted;
		c                   = '0;
		c.instr.math.opType = MATH;
		c.instr.math.dst    = dst;
		c.src1              = s1;
		c.src2              = s2;
		c.src3              = s3;
		issueCommand(c, accepted);
	endtask

	task automatic sendMem(input logic port, input logic store, input index_t dst,
			input data_t addr, input data_t data);
		command_t c;
		logic     accepted;
		c                  = '0;
		c.instr.mem.opType = MEM;
		c.instr.mem.dst    = dst;
		c.instr.mem.port   = port;
		c.instr.mem.store  = store;
		c.src1             = data;
		c.src2             = addr;
		issueCommand(c, accepted);
		if (accepted) begin
			memOps[port]++;
		end
	endtask

	task automatic checkIdleOutputs();
		if (busy !== 1'b0) begin
			logError($sformatf("ERR busy exp 0 got %h", busy));
		end
		if (ldSt !== 2'b00) begin
			logError($sformatf("ERR ldSt exp 0 got %h", ldSt));
		end
		if (done !== 2'b00) begin
			logError($sformatf("ERR done exp 0 got %h", done));
		end
		if (wbValid !== 1'b0) begin
			logError($sformatf("ERR wbValid exp 0 got %h", wbValid));
		end
	endtask

	task automatic checkWriteBack(input wbEntry_t got);
		int       idx;
		wbEntry_t exp;
		idx = -1;
		if (ordered != 0 && expQ.size() > 0) begin
			idx = 0;	// Oldest owed result must come first
		end else begin
			foreach (expQ[i]) begin
				if (idx < 0 && expQ[i].issueNo == got.issueNo) begin
					idx = i;
				end
			end
		end
		if (idx < 0) begin
			logError($sformatf("Test %0d: unexpected write-back for issue %0d",
				testNo, got.issueNo));
		end else begin
			exp = expQ[idx];
			if (got.issueNo != exp.issueNo) begin
				logError($sformatf("ERR wb.issueNo exp %h got %h", exp.issueNo, got.issueNo));
			end
			if (got.dst != exp.dst) begin
				logError($sformatf("ERR wb.dst exp %h got %h", exp.dst, got.dst));
			end
			if (got.data != exp.data) begin
				logError($sformatf("ERR wb.data exp %h got %h", exp.data, got.data));
			end
			expQ.delete(idx);
		end
	endtask

	task automatic finishTest();
		int waited;
		waited = 0;
		while (expQ.size() > 0 && waited < 300) begin
			nextCycles(1);
			waited++;
		end
		nextCycles(2);	// Room for a stray extra write-back
		if (expQ.size() > 0) begin
			logError($sformatf("Test %0d: %0d expected write-backs never arrived",
				testNo, expQ.size()));
		end
		for (int p = 0; p < 2; p++) begin
			if (doneCount[p] != memOps[p]) begin
				logError($sformatf("Test %0d: port %0d gave %0d done pulses for %0d accesses",
					testNo, p, doneCount[p], memOps[p]));
			end
		end
		if (testErrors == 0) begin
			passCount++;
			$display("Test %0d passed", testNo);
		end else begin
			failCount++;
			$display("Test %0d failed with %0d errors", testNo, testErrors);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Background processes
	//////////////////////////////////////////////////////////////////////

	// Stall pattern of stallOn high cycles then stallOff low cycles
	initial begin
		stall = 1'b0;
		forever begin
			nextCycles(1);
			if (stallOn == 0) begin
				stall = 1'b0;
			end else begin
				stall = (phase < stallOn);
				phase = (phase + 1) % (stallOn + stallOff);
			end
		end
	end

	initial begin
		wait (reset === 1'b0);
		servePort(1'b0);
	end

	initial begin
		wait (reset === 1'b0);
		servePort(1'b1);
	end

	// Outputs sampled mid-cycle
	always @(negedge clock) begin
		if (!reset) begin
			if (wbValid) begin
				if (stall) begin
					logError($sformatf("Test %0d: write-back while stall is high", testNo));
				end
				checkWriteBack(wb);
			end
			if (done[0]) begin
				doneCount[0]++;
			end
			if (done[1]) begin
				doneCount[1]++;
			end
		end
	end

	initial begin
		wait (lineCount > 0);
		repeat (lineCount * 40) @(posedge clock);
		$display("Timeout after %0d cycles, the run did not finish", lineCount * 40);
		$display("Something failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Golden file sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int                 fd;
		int                 code;
		int                 num;
		int                 flag;
		data_t              v0;
		data_t              v1;
		data_t              v2;
		data_t              v3;
		wbEntry_t           e;
		logic [7:0]         kind;
		logic [8*160-1:0]   lineBuf;
		clock      = 1'b0;
		reset      = 1'b1;
		cmdValid   = 1'b0;
		cmd        = '0;
		grant      = 2'b00;
		endAccess  = 2'b00;
		ldData     = '0;
		seed       = 32'he833bd1f;
		stallOn    = 0;
		stallOff   = 0;
		phase      = 0;
		testNo     = 0;
		ordered    = 0;
		testErrors = 0;
		passCount  = 0;
		failCount  = 0;
		lineCount  = 0;
		memOps     = '{0, 0};
		doneCount  = '{0, 0};
		for (int i = 0; i < 256; i++) begin
			mem[i] = {8'(i) ^ 8'h5a, ~8'(i), 8'(i), 8'(i) + 8'h11};
		end

		fd = $fopen("verif/execLane_golden.txt", "r");
		if (fd != 0) begin
			while ($fgets(lineBuf, fd) != 0) begin
				lineCount++;
			end
			$fclose(fd);
			fd = $fopen("verif/execLane_golden.txt", "r");
		end

		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;

		if (fd == 0) begin
			$display("Cannot open the golden file");
			failCount++;
		end else begin
			while ($fscanf(fd, "%s", kind) == 1) begin
				case (kind)
					"#": code = $fgets(lineBuf, fd);
					"T": begin
						code       = $fscanf(fd, "%d %d", num, flag);
						testNo     = num;
						ordered    = flag;
						testErrors = 0;
						memOps     = '{0, 0};
						doneCount  = '{0, 0};
						expQ.delete();
					end
					"M": begin
						code = $fscanf(fd, "%h %h %h %h", v0, v1, v2, v3);
						sendMath(v0[4:0], v1, v2, v3);
					end
					"L": begin
						code = $fscanf(fd, "%h %h %h", v0, v1, v2);
						sendMem(v0[0], 1'b0, v1[4:0], v2, '0);
					end
					"S": begin
						code = $fscanf(fd, "%h %h %h", v0, v1, v2);
						sendMem(v0[0], 1'b1, '0, v1, v2);
					end
					"E": begin
						code      = $fscanf(fd, "%h %h %h", v0, v1, v2);
						e.dst     = v0[4:0];
						e.data    = v1;
						e.issueNo = v2[5:0];
						expQ.push_back(e);
					end
					"W": begin
						code = $fscanf(fd, "%d", num);
						nextCycles(num);
					end
					"P": begin
						code     = $fscanf(fd, "%d %d", num, flag);
						stallOn  = num;
						stallOff = flag;
						phase    = 0;
					end
					"Z": checkIdleOutputs();
					"F": finishTest();
					default: logError($sformatf("Unknown golden line kind %s", kind));
				endcase
			end
			$fclose(fd);
		end

		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0 && passCount > 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/execLane_golden.txt
# T test ordered | M dst src1 src2 src3 | L port dst addr | S port addr data | E dst data issue
# W cycles | P stallOn stallOff | Z idle check | F finish; T W P in decimal, others in hex
# Idle after reset
T 1 1
Z
W 10
F
# Multiply-add results in issue order
T 2 1
E 01 00000016 00
E 02 ffffffff 01
E 03 00000005 02
E 1f 23456788 03
M 01 00000003 00000005 00000007
M 02 ffffffff 00000002 00000001
M 03 00010000 00010000 00000005
M 1f 12345678 00000010 00000008
F
# Stores then loads on both ports
T 3 0
E 04 cafef00d 07
E 05 0badbeef 08
E 06 00c0ffee 09
S 0 10 cafef00d
S 1 11 0badbeef
S 0 20 00c0ffee
L 0 04 10
L 1 05 11
L 0 06 20
F
# Results held by stall come out oldest first
T 4 1
E 07 0000000a 0a
E 08 cafef00d 0b
E 09 00010001 0c
E 0a 0badbeef 0d
P 1 0
M 07 00000002 00000003 00000004
L 1 08 10
M 09 00000100 00000100 00000001
L 0 0a 11
W 30
P 0 0
F
# Burst under repeating stall windows
T 5 0
E 0b 00000002 0e
E 0c 00000100 0f
E 0d 00c0ffee 10
E 0e 00000038 11
E 0f a5a5a5a5 13
E 10 00000003 14
E 11 00000006 15
E 12 cafef00d 16
E 13 fffe0001 17
E 14 a5a5a5a5 18
E 15 0000abcd 19
P 6 3
M 0b 00000001 00000001 00000001
M 0c 00000010 00000010 00000000
L 0 0d 20
M 0e 00000007 00000007 00000007
S 1 30 a5a5a5a5
L 1 0f 30
M 10 80000000 00000002 00000003
M 11 00000003 00000003 fffffffd
L 0 12 10
M 13 0000ffff 0000ffff 00000000
L 1 14 30
M 15 00000000 12345678 0000abcd
P 0 0
F

// File: verif/execLane_properties.sv
`timescale 1ns/10ps
`default_nettype none

module execLaneProperties (
	input wire       clock,
	input wire       reset,
	input wire       cmdValid,
	input wire       busy,
	input wire [1:0] ldSt,
	input wire [1:0] grant,
	input wire       stall,
	input wire       wbValid,
	input wire [2:0] pop
);

	noCmdWhileBusy: assert property (@(posedge clock) disable iff (reset)
		cmdValid |-> !busy)
		else $error("cmdValid strobed while busy");

	// Request level is held until the port grants it
	for (genvar p = 0; p < 2; p++) begin : g_port
		ldStHeldToGrant: assert property (@(posedge clock) disable iff (reset)
			$fell(ldSt[p]) |-> $past(grant[p]))
			else $error("ldSt[%0d] fell without a grant", p);
	end

	noWriteBackInStall: assert property (@(posedge clock) disable iff (reset)
		stall |-> !wbValid)
		else $error("wbValid during stall");

	singlePop: assert property (@(posedge clock) disable iff (reset)
		$onehot0(pop))
		else $error("More than one queue popped");

endmodule

`default_nettype wire
